//--- verilog/nnPkg.sv
package nnPkg;

	localparam int numInputs = 15;
	localparam int numNeurons = 4;
	localparam int dataWidth = 16;

	// last slot of each neuron holds its bias
	localparam int weightsPerNeuron = numInputs + 1;
	localparam int weightDepth = numNeurons * weightsPerNeuron;
	localparam int addrWidth = $clog2(weightDepth);

	typedef logic [dataWidth-1:0] word; // two's complement
	typedef logic [addrWidth-1:0] weightAddr;

	typedef struct packed
	{
		word [numInputs-1:0] inputs;
	} activationVec;

	typedef struct packed
	{
		word [numNeurons-1:0] outputs;
	} resultVec;

	// external load port of the weight memory
	typedef struct packed
	{
		logic enable;
		weightAddr addr;
		word data;
	} weightWrite;

	typedef struct packed
	{
		weightAddr addr; // neuron * weightsPerNeuron + slot
	} weightReadReq;

endpackage

//--- verilog/weightMemory.sv
`timescale 1ns/1ps

module weightMemory
	import nnPkg::*;
(
	input logic clk,
	input logic reset,
	input weightWrite weightWr,
	input weightAddr readAddr,
	output word readData
);

	word mem [weightDepth];

	// load port, only used while the layer is idle
	always_ff @(posedge clk)
	begin
		if (weightWr.enable)
		begin
			mem[weightWr.addr] <= weightWr.data;
		end
	end

	// one cycle read latency
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			readData <= '0;
		end
		else
		begin
			readData <= mem[readAddr];
		end
	end

endmodule

//--- verilog/weightArbiter.sv
`timescale 1ns/1ps

module weightArbiter
	import nnPkg::*;
(
	input logic clk,
	input logic reset,
	input logic [numNeurons-1:0] readReq,
	input weightReadReq readAddr [numNeurons],
	output logic [numNeurons-1:0] readAck,
	output weightAddr memAddr
);

	typedef logic [$clog2(numNeurons)-1:0] neuronIdx;
	typedef enum logic [1:0] {arbIdle, arbAddress, arbData} arbState;

	arbState state;
	neuronIdx grant; // current or last granted neuron
	neuronIdx pick;
	logic anyReq;

	// round robin search starting after the last grant
	always_comb
	begin
		anyReq = 1'b0;
		pick = grant;
		for (int i = numNeurons; i >= 1; i--)
		begin
			if (readReq[(int'(grant) + i) % numNeurons])
			begin
				anyReq = 1'b1;
				pick = neuronIdx'((int'(grant) + i) % numNeurons);
			end
		end
	end

	assign memAddr = readAddr[grant].addr;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= arbIdle;
			grant <= neuronIdx'(numNeurons - 1); // so neuron 0 goes first
			readAck <= '0;
		end
		else
		begin
			case (state)
				arbIdle:
					if (anyReq)
					begin
						grant <= pick;
						state <= arbAddress;
					end
				arbAddress:
				begin
					readAck[grant] <= 1'b1; // memory output valid from here
					state <= arbData;
				end
				arbData:
					// release once the neuron has dropped its request
					if (!readReq[grant])
					begin
						readAck[grant] <= 1'b0;
						if (anyReq)
						begin
							grant <= pick;
							state <= arbAddress;
						end
						else
						begin
							state <= arbIdle;
						end
					end
				default:
					state <= arbIdle;
			endcase
		end
	end

endmodule

//--- verilog/neuronUnit.sv
`timescale 1ns/1ps

module neuronUnit
	import nnPkg::*;
#(
	parameter int neuronIndex = 0
)
(
	input logic clk,
	input logic reset,
	input logic start,
	input activationVec activations,
	output logic readReq,
	output weightReadReq readAddr,
	input logic readAck,
	input word readData,
	output word result,
	output logic done
);

	typedef logic [$clog2(weightsPerNeuron)-1:0] slotIdx;
	typedef enum logic [1:0] {nIdle, nFetch, nRelease, nFinish} neuronState;

	neuronState state;
	slotIdx slot;
	word acc;
	word term;
	logic biasSlot;

	assign biasSlot = (slot == slotIdx'(numInputs));
	assign readAddr.addr = weightAddr'(neuronIndex * weightsPerNeuron + int'(slot));

	// product kept to 16 bits, bias added as is
	always_comb
	begin
		if (biasSlot)
		begin
			term = readData;
		end
		else
		begin
			term = word'(readData * activations.inputs[slot]);
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= nIdle;
			slot <= '0;
			readReq <= 1'b0;
			result <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			case (state)
				nIdle:
					if (start)
					begin
						slot <= '0;
						readReq <= 1'b1;
						state <= nFetch;
					end
				nFetch:
					if (readAck)
					begin
						readReq <= 1'b0; // data taken
						state <= nRelease;
					end
				nRelease:
					// wait for the arbiter to drop its ack
					if (!readAck)
					begin
						if (biasSlot)
						begin
							state <= nFinish;
						end
						else
						begin
							slot <= slot + 1'b1;
							readReq <= 1'b1;
							state <= nFetch;
						end
					end
				nFinish:
				begin
					result <= acc[dataWidth-1] ? '0 : acc; // relu
					done <= 1'b1;
					state <= nIdle;
				end
				default:
					state <= nIdle;
			endcase
		end
	end

	// accumulator wraps modulo 2^16
	always_ff @(posedge clk)
	begin
		if (state == nIdle && start)
		begin
			acc <= '0;
		end
		else if (state == nFetch && readAck)
		begin
			acc <= acc + term;
		end
	end

endmodule

//--- verilog/layerSequencer.sv
`timescale 1ns/1ps

module layerSequencer
	import nnPkg::*;
(
	input logic clk,
	input logic reset,
	input logic inReq,
	input activationVec inVec,
	output logic inAck,
	output activationVec activations,
	output logic start,
	input logic [numNeurons-1:0] done,
	input word results [numNeurons],
	output logic resultReq,
	output nnPkg::resultVec resultVec,
	input logic resultAck
);

	typedef enum logic [2:0]
	{
		seqIdle,
		seqInAck,
		seqRun,
		seqResult,
		seqResultRelease
	} seqState;

	seqState state;
	logic [numNeurons-1:0] doneFlags;

	// input vector, held for the whole computation
	always_ff @(posedge clk)
	begin
		if (state == seqIdle && inReq)
		begin
			activations <= inVec;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= seqIdle;
			inAck <= 1'b0;
			start <= 1'b0;
			resultReq <= 1'b0;
			doneFlags <= '0;
			resultVec <= '0;
		end
		else
		begin
			start <= 1'b0;
			doneFlags <= doneFlags | done;
			for (int i = 0; i < numNeurons; i++)
			begin
				if (done[i])
				begin
					resultVec.outputs[i] <= results[i];
				end
			end
			case (state)
				seqIdle:
					if (inReq)
					begin
						inAck <= 1'b1;
						start <= 1'b1;
						doneFlags <= '0;
						state <= seqInAck;
					end
				seqInAck:
					if (!inReq)
					begin
						inAck <= 1'b0;
						state <= seqRun;
					end
				seqRun:
					if (&doneFlags)
					begin
						resultReq <= 1'b1;
						state <= seqResult;
					end
				seqResult:
					if (resultAck)
					begin
						resultReq <= 1'b0;
						state <= seqResultRelease;
					end
				seqResultRelease:
					if (!resultAck)
					begin
						state <= seqIdle; // ready for the next vector
					end
				default:
					state <= seqIdle;
			endcase
		end
	end

endmodule

//--- verilog/neuralLayer.sv
`timescale 1ns/1ps

module neuralLayer
	import nnPkg::*;
(
	input logic clk,
	input logic reset,
	input logic inReq,
	input activationVec inVec,
	output logic inAck,
	output logic resultReq,
	output nnPkg::resultVec resultVec,
	input logic resultAck,
	input weightWrite weightWr
);

	activationVec activations;
	logic start;
	logic [numNeurons-1:0] done;
	word results [numNeurons];
	logic [numNeurons-1:0] readReq;
	logic [numNeurons-1:0] readAck;
	weightReadReq readAddr [numNeurons];
	weightAddr memAddr;
	word readData;

	layerSequencer layerSequencer_i
	(
		.clk(clk),
		.reset(reset),
		.inReq(inReq),
		.inVec(inVec),
		.inAck(inAck),
		.activations(activations),
		.start(start),
		.done(done),
		.results(results),
		.resultReq(resultReq),
		.resultVec(resultVec),
		.resultAck(resultAck)
	);

	// one unit per layer output, all sharing the weight memory
	for (genvar i = 0; i < numNeurons; i++)
	begin : neurons
		neuronUnit #(.neuronIndex(i)) neuronUnit_i
		(
			.clk(clk),
			.reset(reset),
			.start(start),
			.activations(activations),
			.readReq(readReq[i]),
			.readAddr(readAddr[i]),
			.readAck(readAck[i]),
			.readData(readData),
			.result(results[i]),
			.done(done[i])
		);
	end

	weightArbiter weightArbiter_i
	(
		.clk(clk),
		.reset(reset),
		.readReq(readReq),
		.readAddr(readAddr),
		.readAck(readAck),
		.memAddr(memAddr)
	);

	weightMemory weightMemory_i
	(
		.clk(clk),
		.reset(reset),
		.weightWr(weightWr),
		.readAddr(memAddr),
		.readData(readData)
	);

endmodule

//--- tests/clockGen.sv
`timescale 1ns/1ps

module clockGen
(
	output logic clk,
	output logic reset
);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 10 ns period
	end

	initial
	begin
		reset = 1'b1;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

//--- tests/neuralLayer_sva.sv
`timescale 1ns/1ps

module neuralLayer_sva
	import nnPkg::*;
(
	input logic clk,
	input logic reset,
	input logic [numNeurons-1:0] readReq,
	input logic [numNeurons-1:0] readAck
);

	int failures = 0; // polled by the testbench

	oneAck: assert property (@(posedge clk) disable iff (reset) $onehot0(readAck))
	else
	begin
		$error("more than one readAck high");
		failures++;
	end

	for (genvar i = 0; i < numNeurons; i++)
	begin : perNeuron
		ackNeedsReq: assert property (@(posedge clk) disable iff (reset)
			$rose(readAck[i]) |-> readReq[i])
		else
		begin
			$error("readAck[%0d] rose without readReq", i);
			failures++;
		end

		// held until the neuron lets go
		ackHeld: assert property (@(posedge clk) disable iff (reset)
			readAck[i] && readReq[i] |=> readAck[i])
		else
		begin
			$error("readAck[%0d] dropped while readReq was high", i);
			failures++;
		end
	end

endmodule

bind weightArbiter neuralLayer_sva arbiterChecks_i
(
	.clk(clk),
	.reset(reset),
	.readReq(readReq),
	.readAck(readAck)
);

//--- tests/neuralLayerTb.sv
`timescale 1ns/1ps

module neuralLayerTb
	import nnPkg::*;
();

	logic clk;
	logic reset;
	logic inReq;
	activationVec inVec;
	logic inAck;
	logic resultReq;
	resultVec resultOut;
	logic resultAck;
	weightWrite weightWr;

	word pat [263]; // whole pattern file, two load blocks
	logic [31:0] lfsr = 32'h300d;
	int cycleLimit = 0;

	logic prevInAck;
	logic prevResultReq;
	logic prevResultAck;
	resultVec prevResult;
	logic vecOpen; // vector accepted, result not yet acknowledged

	clockGen clockGen_i (.clk(clk), .reset(reset));

	neuralLayer neuralLayer_i
	(
		.clk(clk),
		.reset(reset),
		.inReq(inReq),
		.inVec(inVec),
		.inAck(inAck),
		.resultReq(resultReq),
		.resultVec(resultOut),
		.resultAck(resultAck),
		.weightWr(weightWr)
	);

	task automatic stopOnError(input string why);
		$display("%s", why);
		$display("Errors found");
		$fatal(1);
	endtask

	// taps 32 22 2 1
	function automatic logic [31:0] nextLfsr(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic pickDelay(output int cycles);
		cycles = 0;
		repeat (2)
		begin
			lfsr = nextLfsr(lfsr);
			cycles = (cycles << 1) | int'(lfsr[0]);
		end
	endtask

	function automatic int blockSize(input int count);
		return 1 + weightDepth + count * (numInputs + numNeurons);
	endfunction

	task automatic loadWeights(input int first);
		for (int a = 0; a < weightDepth; a++)
		begin
			weightWr.enable <= 1'b1;
			weightWr.addr <= weightAddr'(a);
			weightWr.data <= pat[first + a];
			@(posedge clk);
		end
		weightWr <= '0;
		@(posedge clk);
	endtask

	task automatic raiseRequest(input int first);
		int delay;
		pickDelay(delay);
		repeat (delay) @(posedge clk);
		for (int i = 0; i < numInputs; i++)
		begin
			inVec.inputs[i] <= pat[first + i];
		end
		inReq <= 1'b1;
	endtask

	// the following vector is offered while the result handshake is still open
	task automatic runVector(input int first, input int nextFirst);
		int delay;
		word expected;
		if (!inReq)
			raiseRequest(first);
		@(posedge clk);
		while (!inAck) @(posedge clk);
		inReq <= 1'b0;
		while (inAck) @(posedge clk);
		while (!resultReq) @(posedge clk);
		pickDelay(delay);
		repeat (delay) @(posedge clk);
		for (int n = 0; n < numNeurons; n++)
		begin
			expected = pat[first + numInputs + n];
			assert (resultOut.outputs[n] == expected)
			else stopOnError($sformatf("error: resultVec.outputs[%0d] expected %h got %h",
				n, expected, resultOut.outputs[n]));
		end
		if (nextFirst >= 0)
			raiseRequest(nextFirst);
		resultAck <= 1'b1;
		while (resultReq) @(posedge clk);
		resultAck <= 1'b0;
	endtask

	// handshake rules seen at the top level ports
	always @(posedge clk)
	begin
		if (reset)
		begin
			prevInAck <= 1'b0;
			prevResultReq <= 1'b0;
			prevResultAck <= 1'b0;
			prevResult <= '0;
			vecOpen <= 1'b0;
		end
		else
		begin
			if (inAck && !prevInAck)
			begin
				assert (inReq) else stopOnError("inAck rose while inReq was low");
				assert (!vecOpen)
				else stopOnError("inAck rose before the previous result was acknowledged");
				vecOpen <= 1'b1;
			end
			if (!inAck && prevInAck)
			begin
				assert (!inReq) else stopOnError("inAck fell while inReq was still high");
			end
			if (resultReq && prevResultReq)
			begin
				assert (resultOut == prevResult)
				else stopOnError($sformatf("error: resultVec changed from %h to %h",
					prevResult, resultOut));
			end
			if (!resultAck && prevResultAck)
				vecOpen <= 1'b0;
			assert (neuralLayer_i.weightArbiter_i.arbiterChecks_i.failures == 0)
			else stopOnError("an assertion on the weight bus failed");
			prevInAck <= inAck;
			prevResultReq <= resultReq;
			prevResultAck <= resultAck;
			prevResult <= resultOut;
		end
	end

	initial
	begin
		wait (cycleLimit > 0);
		repeat (cycleLimit) @(posedge clk);
		stopOnError("timeout: the layer stopped answering its handshakes");
	end

	initial
	begin
		int base;
		int vectors;
		int nextFirst;
		inReq = 1'b0;
		resultAck = 1'b0;
		inVec = '0;
		weightWr = '0;
		$readmemh("tests/layer_patterns.txt", pat);
		vectors = 0;
		for (base = 0; base < $size(pat); base += blockSize(int'(pat[base])))
			vectors += int'(pat[base]);
		cycleLimit = vectors * 400 + 4 * weightDepth + 20; // plus loading
		wait (!reset);
		@(posedge clk);
		assert (!inAck && !resultReq) else stopOnError("inAck or resultReq high after reset");
		assert (resultOut == '0)
		else stopOnError($sformatf("error: resultVec expected 0 got %h", resultOut));
		for (base = 0; base < $size(pat); base += blockSize(int'(pat[base])))
		begin
			loadWeights(base + 1);
			for (int v = 0; v < int'(pat[base]); v++)
			begin
				nextFirst = (v + 1 < int'(pat[base])) ? base + blockSize(v + 1) : -1;
				runVector(base + blockSize(v), nextFirst);
			end
		end
		$display("No errors");
		$finish;
	end

endmodule

//--- src.f
verilog/nnPkg.sv
verilog/weightMemory.sv
verilog/weightArbiter.sv
verilog/neuronUnit.sv
verilog/layerSequencer.sv
verilog/neuralLayer.sv
tests/clockGen.sv
tests/neuralLayer_sva.sv
tests/neuralLayerTb.sv

//--- tests/layer_patterns.txt
// two blocks, each: vector count, 4 lines of 15 weights + bias (one line per neuron),
// then per vector 15 inputs (input 0 first) and 4 expected outputs (neuron 0 first)
0004
0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0000
0002 0002 0002 0002 0002 0002 0002 0002 0002 0002 0002 0002 0002 0002 0002 0010
FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF 0100
1000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0005
0012 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0020 0050 00E0 2005
0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0F00 1E10 0000 0005
0003 5000 5000 5000 5000 5000 5000 5000 5000 5000 5000 5000 5000 5000 5000 6003 0000 0000 3005
FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF 0000 0000 010F 0000
// second load, new weights
0003
0003 0003 0003 0003 0003 0003 0003 0003 0003 0003 0003 0003 0003 0003 0003 0001
0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 8000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 1234
0002 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 FFFF
0012 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0061 0000 1234 0023
0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 2D01 0000 1234 01FF
6000 6000 6000 6000 6000 6000 6000 6000 6000 6000 6000 6000 6000 6000 6000 0000 2000 1234 0000
